// ==== bench/stimulus.mem ====
// Columns: kind (1 write, 2 read, 3 write-count read), address, length in bytes,
// then one word per 4 bytes of length, write data or expected read words
// Kind 3 carries no words, kind 0 ends the list

// Word-mode burst into the buffer memory, then read back
1 00001000 00000020
  01234567 89abcdef deadbeef cafef00d 13579bdf 2468ace0 0f1e2d3c 4b5a6978
2 00001000 00000020
  01234567 89abcdef deadbeef cafef00d 13579bdf 2468ace0 0f1e2d3c 4b5a6978

// Scratch register round trip
1 00000004 00000004 5ca1ab1e
2 00000004 00000004 5ca1ab1e

// Set byte mode, then read control as four bytes
1 00000000 00000004 00000001
2 00000000 00000004 00000001

// Six bytes from two host words, then seven bytes back
1 00001010 00000006 a1b2c3d4 7788e5f6
2 00001010 00000007 a1b2c3d4 0068e5f6

// Single byte write clears byte mode, then word reads of the same span
1 00000000 00000001 00000000
2 00001010 00000008 a1b2c3d4 2468e5f6

// Write counter
3 00000008 00000004
0

// ==== project.f ====
logic/fx3Pkg.sv
logic/busPkg.sv
logic/fx3Bridge.sv
logic/bridgeConfig.sv
logic/bufferMemory.sv
logic/busDecoder.sv
logic/fx3Subsystem.sv
bench/fx3SubsystemTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the fx3Subsystem testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module fx3SubsystemTb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/simv)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TEST OK$"; then
    exit 0
fi
exit 1

// ==== bench/fx3SubsystemTb.sv ====
module fx3SubsystemTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 200;   // Cycles allowed per wait loop
    localparam int STIM_DEPTH = 256;
    localparam int IDLE_GAP   = 4;     // Cycles with cs low between transactions

    logic             BUS_CLK = 1'b0;
    logic             BUS_RST;
    fx3Pkg::hostReq_t hostReq;
    fx3Pkg::hostRsp_t hostRsp;
    fx3Pkg::hostRsp_t rsp;             // Outputs as seen at the last falling edge

    logic [31:0] stim [STIM_DEPTH];
    logic [31:0] words [$];            // Write data or expected read words
    int          errorCount  = 0;
    int          testCount   = 0;
    int          failedTests = 0;
    int          testNum     = 0;
    bit          timedOut    = 1'b0;
    bit          modeShadow  = 1'b0;   // Byte mode the bridge latches next
    int          writeTally  = 0;      // Bus writes implied so far

    fx3Subsystem #(
        .MEM_WORDS (256)
    ) u_dut (
        .BUS_CLK (BUS_CLK),
        .BUS_RST (BUS_RST),
        .hostReq (hostReq),
        .hostRsp (hostRsp)
    );

    always #50 BUS_CLK = ~BUS_CLK;

    ////////////////////////////////////////////////////////////////////////////
    // Cycle helpers and checks

    task automatic reportValue(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("Error at %0t: test %0d %s is %h, expected %h",
                 $time, testNum, what, got, exp);
        errorCount++;
    endtask

    // Sample on the falling edge and return on the next rising edge
    task automatic nextCycle();
        @(negedge BUS_CLK);
        rsp = hostRsp;
        assert (rsp.dataOe == (hostReq.oe && hostReq.cs))
        else reportValue("dataOe", 32'(rsp.dataOe), 32'(hostReq.oe && hostReq.cs));
        @(posedge BUS_CLK);
    endtask

    task automatic checkQuiet();
        assert (!rsp.rdy) else reportValue("rdy", 32'(rsp.rdy), 32'd0);
        assert (!rsp.ack) else reportValue("ack", 32'(rsp.ack), 32'd0);
        assert (!rsp.rdFinish) else reportValue("rdFinish", 32'(rsp.rdFinish), 32'd0);
        assert (!rsp.dataOe) else reportValue("dataOe", 32'(rsp.dataOe), 32'd0);
    endtask

    task automatic openTransaction(input logic [31:0] addr, input logic [31:0] len,
                                   input logic isRead);
        hostReq.cs   <= 1'b1;
        hostReq.wr   <= 1'b0;
        hostReq.oe   <= 1'b0;
        hostReq.data <= addr;
        nextCycle();
        hostReq.data <= len;
        hostReq.oe   <= isRead;   // Bridge picks the direction from oe here
    endtask

    task automatic closeTransaction();
        hostReq.cs <= 1'b0;
        hostReq.wr <= 1'b0;
        hostReq.oe <= 1'b0;
        repeat (IDLE_GAP)
        begin
            nextCycle();
            checkQuiet();   // Also catches a second rdFinish
        end
    endtask

    task automatic finishTest(input string what, input int errBefore);
        testCount++;
        if (errorCount == errBefore && !timedOut)
            $display("Test %0d %s: passed", testNum, what);
        else
        begin
            failedTests++;
            $display("Test %0d %s: failed", testNum, what);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Host transactions

    task automatic runWrite(input logic [31:0] addr, input logic [31:0] len);
        int sent;
        int waited;
        sent   = 0;
        waited = 0;
        openTransaction(addr, len, 1'b0);
        while (sent < words.size() && !timedOut)
        begin
            nextCycle();
            if (rsp.rdy)   // One word per cycle after rdy
            begin
                hostReq.wr   <= 1'b1;
                hostReq.data <= words[sent];
                sent++;
                waited = 0;
            end
            else
            begin
                hostReq.wr <= 1'b0;
                waited++;
                if (waited > WAIT_LIMIT)
                begin
                    $display("Timeout in test %0d: rdy did not rise within %0d cycles",
                             testNum, WAIT_LIMIT);
                    timedOut = 1'b1;
                end
            end
        end
        nextCycle();   // Last word sampled before cs drops
        closeTransaction();
    endtask

    task automatic runRead(input logic [31:0] addr, input logic [31:0] len);
        int got;
        int waited;
        bit lastAck;
        bit finished;
        got      = 0;
        waited   = 0;
        lastAck  = 1'b0;
        finished = 1'b0;
        openTransaction(addr, len, 1'b1);
        while (!finished && !timedOut)
        begin
            nextCycle();
            if (rsp.ack)
            begin
                if (got < words.size())
                begin
                    assert (rsp.data == words[got])
                    else reportValue($sformatf("read word %0d", got), rsp.data, words[got]);
                end
                got++;
            end
            if (rsp.rdFinish)
            begin
                finished = 1'b1;
                assert (lastAck && !rsp.ack)   // Exactly one cycle after the last ack
                else reportValue("ack in cycle before rdFinish", 32'(lastAck), 32'd1);
            end
            lastAck = rsp.ack;
            waited++;
            if (!finished && waited > WAIT_LIMIT)
            begin
                $display("Timeout in test %0d: rdFinish did not arrive within %0d cycles",
                         testNum, WAIT_LIMIT);
                timedOut = 1'b1;
            end
        end
        assert (got == words.size()) else reportValue("ack count", 32'(got), 32'(words.size()));
        closeTransaction();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial
    begin
        int          idx;
        int          nWords;
        int          errBefore;
        logic [31:0] kind;
        logic [31:0] addr;
        logic [31:0] len;

        $timeformat(-9, 0, " ns", 0);
        BUS_RST <= 1'b1;
        hostReq <= '0;
        rsp = '0;
        for (int i = 0; i < STIM_DEPTH; i++)
            stim[i] = '0;
        $readmemh("bench/stimulus.mem", stim);

        // Outputs stay low over five rising edges of reset
        testNum   = 1;
        errBefore = errorCount;
        @(posedge BUS_CLK);
        repeat (4)
        begin
            nextCycle();
            checkQuiet();
        end
        BUS_RST    <= 1'b0;
        hostReq.oe <= 1'b1;   // oe without cs must not enable the data lines
        repeat (3)
        begin
            nextCycle();
            checkQuiet();
        end
        hostReq.oe <= 1'b0;
        finishTest("reset", errBefore);

        idx = 0;
        while (idx + 2 < STIM_DEPTH && stim[idx] != 32'd0 && !timedOut)
        begin
            kind   = stim[idx];
            addr   = stim[idx+1];
            len    = stim[idx+2];
            nWords = int'((len + 32'd3) >> 2);
            idx += 3;
            testNum++;
            errBefore = errorCount;
            words.delete();
            if (kind == 32'd3)
                words.push_back(32'(writeTally));   // Expected count from the tally
            else
            begin
                for (int i = 0; i < nWords && idx < STIM_DEPTH; i++)
                begin
                    words.push_back(stim[idx]);
                    idx++;
                end
            end

            if (kind == 32'd1)
            begin
                // One bus write per word, or per byte in byte mode
                writeTally += modeShadow ? int'(len) : int'(len >> 2);
                if (addr == busPkg::CFG_BASE + 32'(busPkg::REG_CONTROL))
                    modeShadow = words[0][busPkg::CTRL_BYTE_MODE];
                runWrite(addr, len);
                finishTest($sformatf("write %h len %0d", addr, len), errBefore);
            end
            else
            begin
                runRead(addr, len);
                finishTest($sformatf("read %h len %0d", addr, len), errBefore);
            end
        end

        assert (testNum > 1)
        else
        begin
            $display("No transactions were read from bench/stimulus.mem");
            errorCount++;
        end

        $display("Tests run %0d, tests failed %0d, errors %0d",
                 testCount, failedTests, errorCount);
        if (errorCount == 0 && !timedOut)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== logic/fx3Subsystem.sv ====
module fx3Subsystem #(
    parameter int MEM_WORDS = 256
) (
    input  logic             BUS_CLK,
    input  logic             BUS_RST,
    input  fx3Pkg::hostReq_t hostReq,
    output fx3Pkg::hostRsp_t hostRsp
);

    busPkg::busReq_t busReq;
    busPkg::busRsp_t busRsp;
    logic            cfgSel;
    logic            memSel;
    logic            byteMode;
    logic [31:0]     cfgRdData;
    logic [31:0]     memRdData;

    // Host port to internal bus
    fx3Bridge uBridge (
        .BUS_CLK  (BUS_CLK),
        .BUS_RST  (BUS_RST),
        .hostReq  (hostReq),
        .hostRsp  (hostRsp),
        .byteMode (byteMode),
        .busReq   (busReq),
        .busRsp   (busRsp)
    );

    busDecoder #(
        .MEM_WORDS (MEM_WORDS)
    ) uDecoder (
        .BUS_CLK   (BUS_CLK),
        .BUS_RST   (BUS_RST),
        .busReq    (busReq),
        .cfgSel    (cfgSel),
        .memSel    (memSel),
        .cfgRdData (cfgRdData),
        .memRdData (memRdData),
        .busRsp    (busRsp)
    );

    bridgeConfig uConfig (
        .BUS_CLK  (BUS_CLK),
        .BUS_RST  (BUS_RST),
        .busReq   (busReq),
        .sel      (cfgSel),
        .rdData   (cfgRdData),
        .byteMode (byteMode)   // Steers the bridge
    );

    bufferMemory #(
        .MEM_WORDS (MEM_WORDS)
    ) uMemory (
        .BUS_CLK (BUS_CLK),
        .busReq  (busReq),
        .sel     (memSel),
        .rdData  (memRdData)
    );

endmodule

// ==== logic/busDecoder.sv ====
module busDecoder #(
    parameter int MEM_WORDS = 256
) (
    input  logic            BUS_CLK,
    input  logic            BUS_RST,
    input  busPkg::busReq_t busReq,
    output logic            cfgSel,
    output logic            memSel,
    input  logic [31:0]     cfgRdData,
    input  logic [31:0]     memRdData,
    output busPkg::busRsp_t busRsp
);

    localparam logic [31:0] MEM_BYTES = 32'(MEM_WORDS * 4);

    logic cfgRdQ;
    logic memRdQ;

    // Offset compare that wraps below the base
    assign cfgSel = (busReq.addr - busPkg::CFG_BASE) < busPkg::CFG_SIZE;
    assign memSel = (busReq.addr - busPkg::MEM_BASE) < MEM_BYTES;

    // Select follows rd by one cycle to meet the returning data
    always_ff @(posedge BUS_CLK)
    begin
        if (BUS_RST)
        begin
            cfgRdQ <= 1'b0;
            memRdQ <= 1'b0;
        end
        else
        begin
            cfgRdQ <= cfgSel && busReq.rd;
            memRdQ <= memSel && busReq.rd;
        end
    end

    always_comb
    begin
        if (cfgRdQ)
            busRsp.rdData = cfgRdData;
        else if (memRdQ)
            busRsp.rdData = memRdData;
        else
            busRsp.rdData = '0;   // Unmapped
    end

endmodule

// ==== logic/bufferMemory.sv ====
module bufferMemory #(
    parameter int MEM_WORDS = 256
) (
    input  logic            BUS_CLK,
    input  busPkg::busReq_t busReq,
    input  logic            sel,
    output logic [31:0]     rdData
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [31:0]      mem [MEM_WORDS];
    logic [IDX_W-1:0] wordIdx;
    logic [1:0]       lane;
    logic [3:0]       byteEn;
    logic [31:0]      wrWord;
    logic [31:0]      rdWord;

    assign wordIdx = busReq.addr[IDX_W+1:2];
    assign lane    = busReq.addr[1:0];
    assign byteEn  = busReq.byteAccess ? (4'b0001 << lane) : 4'b1111;
    assign wrWord  = busReq.byteAccess ? {4{busReq.wrData[7:0]}} : busReq.wrData;
    assign rdWord  = mem[wordIdx];

    always_ff @(posedge BUS_CLK)
    begin
        if (sel && busReq.wr)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (byteEn[i])
                    mem[wordIdx][i*8 +: 8] <= wrWord[i*8 +: 8];
            end
        end

        if (sel && busReq.rd)
        begin
            if (busReq.byteAccess)
                rdData <= {24'h0, rdWord[lane*8 +: 8]};   // Byte comes back in lane 0
            else
                rdData <= rdWord;
        end
    end

endmodule

// ==== logic/bridgeConfig.sv ====
module bridgeConfig (
    input  logic            BUS_CLK,
    input  logic            BUS_RST,
    input  busPkg::busReq_t busReq,
    input  logic            sel,
    output logic [31:0]     rdData,
    output logic            byteMode
);

    busPkg::cfgOffset_t regOffset;
    logic               regWrite;
    logic               byteModeQ;
    logic [31:0]        scratchQ;
    logic [31:0]        writeCountQ;
    logic [31:0]        controlWord;

    assign regOffset   = busReq.addr[busPkg::CFG_OFFSET_W-1:0];
    assign regWrite    = sel && busReq.wr;
    assign controlWord = 32'(byteModeQ) << busPkg::CTRL_BYTE_MODE;

    // Registers answer on their word offset only
    // A byte write there loads the zero extended byte
    always_ff @(posedge BUS_CLK)
    begin
        if (BUS_RST)
        begin
            byteModeQ   <= 1'b0;
            scratchQ    <= '0;
            writeCountQ <= '0;
        end
        else
        begin
            if (busReq.wr)
                writeCountQ <= writeCountQ + 32'd1;   // Any write strobe on the bus
            if (regWrite && regOffset == busPkg::REG_CONTROL)
                byteModeQ <= busReq.wrData[busPkg::CTRL_BYTE_MODE];
            if (regWrite && regOffset == busPkg::REG_SCRATCH)
                scratchQ <= busReq.wrData;
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (sel && busReq.rd)
        begin
            case (regOffset)
                busPkg::REG_CONTROL:     rdData <= controlWord;
                busPkg::REG_SCRATCH:     rdData <= scratchQ;
                busPkg::REG_WRITE_COUNT: rdData <= writeCountQ;
                default:                 rdData <= '0;
            endcase
        end
    end

    assign byteMode = byteModeQ;

endmodule

// ==== logic/fx3Bridge.sv ====
module fx3Bridge (
    input  logic             BUS_CLK,
    input  logic             BUS_RST,
    input  fx3Pkg::hostReq_t hostReq,
    output fx3Pkg::hostRsp_t hostRsp,
    input  logic             byteMode,
    output busPkg::busReq_t  busReq,
    input  busPkg::busRsp_t  busRsp
);

    typedef enum logic [2:0] {
        IDLE,
        ADDR,
        LENGTH,
        WR_STREAM,
        RD_STREAM,
        FINISH
    } state_t;

    state_t           state;
    fx3Pkg::hostReq_t reqQ;         // Host inputs after the input register
    logic             modeQ;        // Byte mode, frozen per transaction
    logic [31:0]      addrCnt;
    logic [31:0]      lenQ;         // Transfer length in bytes
    logic [31:0]      byteCnt;      // Bytes already put on the bus
    logic [30:0]      wordsLeft;    // Host words not yet asked for
    logic [31:0]      wrShift;      // Rest of the word being unpacked
    logic             unpacking;
    busPkg::busReq_t  busReqQ;

    logic             startReq;
    logic [30:0]      lenWords;
    logic [31:0]      step;
    logic             lastByte;
    logic             wordDone;
    logic             lastReq;
    logic             wrIssue;
    logic [31:0]      byteSrc;

    // Tags that travel with a read until its data returns
    logic [1:0]       issueLane;
    logic             issueEnd;
    logic             issueFinal;
    logic [1:0]       retLane;
    logic             retValid;
    logic             retEnd;
    logic             retFinal;

    logic [31:0]      packQ;
    logic [31:0]      packNext;
    logic [31:0]      hostDataQ;
    logic             rdyQ;
    logic             ackQ;
    logic             lastAckQ;
    logic             rdFinishQ;

    assign startReq = hostReq.cs && !reqQ.cs;   // Address word in flight on rising cs
    assign lenWords = 31'(({1'b0, reqQ.data} + 33'd3) >> 2);
    assign step     = modeQ ? 32'd1 : 32'd4;
    assign lastByte = (byteCnt + 32'd1 == lenQ);
    assign wordDone = modeQ ? (byteCnt[1:0] == 2'd3 || lastByte) : 1'b1;
    assign lastReq  = modeQ ? lastByte : (byteCnt + 32'd4 >= lenQ);
    assign wrIssue  = reqQ.wr || (modeQ && unpacking);
    assign byteSrc  = unpacking ? wrShift : reqQ.data;

    ////////////////////////////////////////////////////////////////////////////
    // Transaction FSM and request side

    always_ff @(posedge BUS_CLK)
    begin
        if (BUS_RST)
        begin
            state      <= IDLE;
            reqQ       <= '0;
            modeQ      <= 1'b0;
            addrCnt    <= '0;
            lenQ       <= '0;
            byteCnt    <= '0;
            wordsLeft  <= '0;
            wrShift    <= '0;
            unpacking  <= 1'b0;
            busReqQ    <= '0;
            rdyQ       <= 1'b0;
            issueLane  <= '0;
            issueEnd   <= 1'b0;
            issueFinal <= 1'b0;
        end
        else
        begin
            reqQ       <= hostReq;
            busReqQ.wr <= 1'b0;
            busReqQ.rd <= 1'b0;

            case (state)
                IDLE:
                begin
                    if (startReq)
                    begin
                        modeQ <= byteMode;   // Mode changes apply per transaction
                        state <= ADDR;
                    end
                end
                ADDR:
                begin
                    addrCnt <= reqQ.data;
                    state   <= LENGTH;
                end
                LENGTH:
                begin
                    lenQ      <= reqQ.data;
                    byteCnt   <= '0;
                    unpacking <= 1'b0;
                    if (reqQ.data == 32'd0)
                        state <= FINISH;
                    else if (reqQ.oe)
                        state <= RD_STREAM;   // oe is up by the length word on a read
                    else
                    begin
                        state     <= WR_STREAM;
                        rdyQ      <= 1'b1;    // First word request
                        wordsLeft <= lenWords - 31'd1;
                    end
                end
                WR_STREAM:
                begin
                    // Word mode keeps rdy up one cycle per remaining word
                    rdyQ <= !modeQ && wordsLeft != '0;
                    if (!modeQ && wordsLeft != '0)
                        wordsLeft <= wordsLeft - 31'd1;

                    if (wrIssue)
                    begin
                        busReqQ.wr         <= 1'b1;
                        busReqQ.addr       <= addrCnt;
                        busReqQ.byteAccess <= modeQ;
                        busReqQ.wrData     <= modeQ ? {24'h0, byteSrc[7:0]} : reqQ.data;
                        addrCnt            <= addrCnt + step;
                        byteCnt            <= byteCnt + step;
                        unpacking          <= modeQ && !wordDone;
                        wrShift            <= {8'h00, byteSrc[31:8]};   // LSB first

                        // In byte mode the next word is asked for once this one is used up
                        if (modeQ && wordDone && wordsLeft != '0)
                        begin
                            rdyQ      <= 1'b1;
                            wordsLeft <= wordsLeft - 31'd1;
                        end
                        if (lastReq)
                            state <= FINISH;
                    end
                end
                RD_STREAM:
                begin
                    if (reqQ.oe)   // oe low holds off new reads
                    begin
                        busReqQ.rd         <= 1'b1;
                        busReqQ.addr       <= addrCnt;
                        busReqQ.byteAccess <= modeQ;
                        addrCnt            <= addrCnt + step;
                        byteCnt            <= byteCnt + step;
                        issueLane          <= modeQ ? byteCnt[1:0] : 2'd0;
                        issueEnd           <= wordDone;
                        issueFinal         <= lastReq;
                        if (lastReq)
                            state <= FINISH;
                    end
                end
                FINISH:
                begin
                    rdyQ <= 1'b0;
                    if (!hostReq.cs)   // Wait for the host to close the transaction
                        state <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read return, packing and host strobes

    always_ff @(posedge BUS_CLK)
    begin
        if (BUS_RST)
        begin
            retValid  <= 1'b0;
            retLane   <= '0;
            retEnd    <= 1'b0;
            retFinal  <= 1'b0;
            ackQ      <= 1'b0;
            lastAckQ  <= 1'b0;
            rdFinishQ <= 1'b0;
        end
        else
        begin
            retValid  <= busReqQ.rd;   // Slave data shows up the cycle after this
            retLane   <= issueLane;
            retEnd    <= issueEnd;
            retFinal  <= issueFinal;
            ackQ      <= retValid && retEnd;
            lastAckQ  <= retValid && retFinal;
            rdFinishQ <= lastAckQ;     // One cycle behind the last ack
        end
    end

    always_comb
    begin
        packNext = (retLane == 2'd0) ? 32'h0 : packQ;   // New word starts zero filled
        packNext[retLane*8 +: 8] = busRsp.rdData[7:0];
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (retValid)
        begin
            packQ <= packNext;
            if (retEnd)
                hostDataQ <= modeQ ? packNext : busRsp.rdData;
        end
    end

    assign hostRsp.data     = hostDataQ;
    assign hostRsp.dataOe   = hostReq.oe && hostReq.cs;
    assign hostRsp.rdy      = rdyQ;
    assign hostRsp.ack      = ackQ;
    assign hostRsp.rdFinish = rdFinishQ;

    assign busReq = busReqQ;

endmodule

// ==== logic/busPkg.sv ====
package busPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Internal bus

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wrData;
        logic        wr;          // Single cycle write strobe
        logic        rd;          // Single cycle read strobe
        logic        byteAccess;  // One byte per access, low lane of wrData
    } busReq_t;

    // Read data comes one cycle after the rd strobe
    typedef struct packed {
        logic [31:0] rdData;
    } busRsp_t;

    ////////////////////////////////////////////////////////////////////////////
    // Address map

    localparam logic [31:0] CFG_BASE = 32'h0000_0000;
    localparam int unsigned CFG_SIZE = 16;   // Bytes
    localparam logic [31:0] MEM_BASE = 32'h0000_1000;

    localparam int CFG_OFFSET_W = $clog2(CFG_SIZE);

    typedef logic [CFG_OFFSET_W-1:0] cfgOffset_t;

    // Configuration register offsets
    localparam cfgOffset_t REG_CONTROL     = 'h0;
    localparam cfgOffset_t REG_SCRATCH     = 'h4;
    localparam cfgOffset_t REG_WRITE_COUNT = 'h8;   // Read only

    localparam int CTRL_BYTE_MODE = 0;   // Bit in REG_CONTROL

endpackage

// ==== logic/fx3Pkg.sv ====
package fx3Pkg;

    // Host side of the slave-FIFO port, as seen by the bridge
    typedef struct packed {
        logic        cs;        // Frames one transaction
        logic        wr;        // Data word valid on a write
        logic        oe;        // Host wants read data
        logic [31:0] data;      // Address, length or write data
    } hostReq_t;

    // Bridge outputs back to the host
    typedef struct packed {
        logic [31:0] data;      // Read word
        logic        dataOe;    // Bridge owns the data lines
        logic        rdy;       // Next write word may follow
        logic        ack;       // Read word valid
        logic        rdFinish;  // Read burst done
    } hostRsp_t;

endpackage
